// File: logic/game_pkg.sv
`default_nettype none

package game_pkg;

    // ------------------------------------------------------------------
    // Types

    typedef logic [9:0] coord_t;
    typedef logic [2:0] rgb_t;

    typedef enum logic [1:0] {
        st_idle,
        st_play,
        st_over
    } game_state_t;

    // ------------------------------------------------------------------
    // Sprite tables, indexed by sprite number

    localparam int max_sprites = 4;

    localparam coord_t sprite_start_x [max_sprites] = '{10'd20, 10'd18, 10'd200, 10'd400};
    localparam coord_t sprite_start_y [max_sprites] = '{10'd0, 10'd4, 10'd8, 10'd12};
    localparam int     sprite_dx      [max_sprites] = '{1, 2, 3, 2};

    // Green, blue, yellow, cyan
    localparam rgb_t sprite_colour [max_sprites] = '{3'b010, 3'b001, 3'b110, 3'b011};

    // ------------------------------------------------------------------
    // Colours and object sizes

    localparam rgb_t colour_paddle = 3'b111;
    localparam rgb_t colour_over   = 3'b100;
    localparam rgb_t colour_bg     = 3'b000;

    localparam int sprite_size   = 8;
    localparam int paddle_width  = 16;
    localparam int paddle_height = 4;
    localparam int paddle_step   = 4;

endpackage

`default_nettype wire

// File: logic/vga_timing.sv
`default_nettype none

module vga_timing #(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25,
    parameter int h_active  = 640,
    parameter int h_front   = 16,
    parameter int h_sync    = 96,
    parameter int h_back    = 48,
    parameter int v_active  = 480,
    parameter int v_front   = 10,
    parameter int v_sync    = 2,
    parameter int v_back    = 33
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              pix_en,
    output logic              pixel_clk,
    output game_pkg::coord_t  x,
    output game_pkg::coord_t  y,
    output logic              raw_hsync,
    output logic              raw_vsync,
    output logic              raw_active,
    output logic              frame_end
);

    localparam int div   = clk_mhz / pixel_mhz;
    localparam int w_div = (div > 1) ? $clog2(div) : 1;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    logic [w_div-1:0] div_cnt;

    // ------------------------------------------------------------------
    // Pixel enable and the board pixel clock

    assign pix_en = (div_cnt == w_div'(div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            pixel_clk <= 1'b0;
        end else if (pix_en) begin
            div_cnt   <= '0;
            pixel_clk <= ~pixel_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Raster counters

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (pix_en) begin
            if (x == game_pkg::coord_t'(h_total - 1)) begin
                x <= '0;
                if (y == game_pkg::coord_t'(v_total - 1))
                    y <= '0;
                else
                    y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Sync pulses are active low
    assign raw_hsync = !(x >= h_active + h_front && x < h_active + h_front + h_sync);
    assign raw_vsync = !(y >= v_active + v_front && y < v_active + v_front + v_sync);

    assign raw_active = (x < h_active) && (y < v_active);

    // Last pixel of the last visible line
    assign frame_end = pix_en && x == game_pkg::coord_t'(h_active - 1)
                              && y == game_pkg::coord_t'(v_active - 1);

    sync_outside_active: assert property (
        @(posedge clk) disable iff (!rst_n) raw_active |-> raw_hsync && raw_vsync
    );

endmodule

`default_nettype wire

// File: logic/game_control.sv
`default_nettype none

module game_control #(
    parameter int h_active                          = 640,
    parameter int strobe_to_update_xy_counter_width = 20,
    parameter int n_sprites                         = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   launch_key,
    input  logic [1:0]             left_right_keys,
    input  logic [n_sprites-1:0]   bottom,
    input  logic [n_sprites-1:0]   caught,
    output logic                   step,
    output logic [n_sprites-1:0]   respawn,
    output game_pkg::coord_t       paddle_x,
    output game_pkg::game_state_t  state
);

    localparam game_pkg::coord_t paddle_max =
        game_pkg::coord_t'(h_active - game_pkg::paddle_width);
    localparam game_pkg::coord_t paddle_mid = paddle_max / 2;
    localparam game_pkg::coord_t move       = game_pkg::coord_t'(game_pkg::paddle_step);

    logic [strobe_to_update_xy_counter_width-1:0] upd_cnt;
    logic tick;
    logic launch;

    // ------------------------------------------------------------------
    // Update strobe

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            upd_cnt <= '0;
        else
            upd_cnt <= upd_cnt + 1'b1;
    end

    assign tick = &upd_cnt;

    // Sprites only see the strobe during play
    assign step = tick && state == game_pkg::st_play;

    assign launch = launch_key && state != game_pkg::st_play;

    // ------------------------------------------------------------------
    // Game FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= game_pkg::st_idle;
        end else begin
            case (state)
                game_pkg::st_idle,
                game_pkg::st_over:
                    if (launch_key)
                        state <= game_pkg::st_play;
                game_pkg::st_play:
                    if (|bottom)
                        state <= game_pkg::st_over;
                default:
                    state <= game_pkg::st_idle;
            endcase
        end
    end

    // All sprites restart on launch, a caught one restarts alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            respawn <= '0;
        else if (launch)
            respawn <= '1;
        else
            respawn <= caught;
    end

    // ------------------------------------------------------------------
    // Paddle, clamped to the screen

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddle_x <= paddle_mid;
        end else if (launch) begin
            paddle_x <= paddle_mid;
        end else if (tick && state != game_pkg::st_over) begin
            case (left_right_keys)
                2'b10:
                    if (paddle_x < move)
                        paddle_x <= '0;
                    else
                        paddle_x <= paddle_x - move;
                2'b01:
                    if (paddle_max - paddle_x < move)
                        paddle_x <= paddle_max;
                    else
                        paddle_x <= paddle_x + move;
                default:
                    paddle_x <= paddle_x;
            endcase
        end
    end

    step_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) step |=> !step
    );

    paddle_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) paddle_x <= paddle_max
    );

endmodule

`default_nettype wire

// File: logic/game_sprite.sv
`default_nettype none

module game_sprite #(
    parameter int               h_active = 640,
    parameter int               v_active = 480,
    parameter game_pkg::coord_t start_x  = '0,
    parameter game_pkg::coord_t start_y  = '0,
    parameter int               dx       = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             step,
    input  logic             respawn,
    input  game_pkg::coord_t x,
    input  game_pkg::coord_t y,
    output logic             hit,
    output logic             bottom
);

    localparam game_pkg::coord_t size   = game_pkg::coord_t'(game_pkg::sprite_size);
    localparam game_pkg::coord_t x_max  = game_pkg::coord_t'(h_active - game_pkg::sprite_size);
    localparam game_pkg::coord_t y_last = game_pkg::coord_t'(v_active - game_pkg::sprite_size);
    localparam game_pkg::coord_t dy     = size / 2;
    localparam game_pkg::coord_t dx_c   = game_pkg::coord_t'(dx);

    game_pkg::coord_t pos_x;
    game_pkg::coord_t pos_y;
    logic             going_left;
    logic             stopped;

    // ------------------------------------------------------------------
    // Motion

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_x      <= start_x;
            pos_y      <= start_y;
            going_left <= 1'b0;
            stopped    <= 1'b0;
            bottom     <= 1'b0;
        end else if (respawn) begin
            pos_x      <= start_x;
            pos_y      <= start_y;
            going_left <= 1'b0;
            stopped    <= 1'b0;
            bottom     <= 1'b0;
        end else begin
            bottom <= 1'b0;
            if (step && !stopped) begin
                // Resting on the last row for one update ends the fall
                if (pos_y >= y_last) begin
                    bottom  <= 1'b1;
                    stopped <= 1'b1;
                end else begin
                    if (y_last - pos_y < dy)
                        pos_y <= y_last;
                    else
                        pos_y <= pos_y + dy;

                    // Sideways bounce between the screen edges
                    if (going_left) begin
                        if (pos_x <= dx_c) begin
                            pos_x      <= '0;
                            going_left <= 1'b0;
                        end else begin
                            pos_x <= pos_x - dx_c;
                        end
                    end else begin
                        if (x_max - pos_x <= dx_c) begin
                            pos_x      <= x_max;
                            going_left <= 1'b1;
                        end else begin
                            pos_x <= pos_x + dx_c;
                        end
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Current pixel inside the square

    assign hit = x >= pos_x && x < pos_x + size
              && y >= pos_y && y < pos_y + size;

    x_inside_screen: assert property (
        @(posedge clk) disable iff (!rst_n) pos_x <= x_max
    );

endmodule

`default_nettype wire

// File: logic/game_mixer.sv
`default_nettype none

module game_mixer #(
    parameter int v_active  = 480,
    parameter int n_sprites = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_en,
    input  game_pkg::coord_t      x,
    input  game_pkg::coord_t      y,
    input  logic                  raw_hsync,
    input  logic                  raw_vsync,
    input  logic                  raw_active,
    input  logic [n_sprites-1:0]  hit,
    input  game_pkg::coord_t      paddle_x,
    input  game_pkg::game_state_t state,
    output logic [n_sprites-1:0]  caught,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  display_on,
    output game_pkg::rgb_t        rgb
);

    localparam game_pkg::coord_t paddle_top =
        game_pkg::coord_t'(v_active - game_pkg::paddle_height);
    localparam game_pkg::coord_t paddle_w = game_pkg::coord_t'(game_pkg::paddle_width);

    logic           in_paddle;
    game_pkg::rgb_t sprite_rgb;
    game_pkg::rgb_t pixel_rgb;

    // Paddle sits on the bottom rows
    assign in_paddle = y >= paddle_top && x >= paddle_x && x < paddle_x + paddle_w;

    // Lowest index wins where sprites overlap
    always_comb begin
        sprite_rgb = game_pkg::colour_bg;
        for (int i = n_sprites - 1; i >= 0; i--) begin
            if (hit[i])
                sprite_rgb = game_pkg::sprite_colour[i];
        end
    end

    always_comb begin
        if (!raw_active)
            pixel_rgb = '0;
        else if (state == game_pkg::st_over)
            pixel_rgb = game_pkg::colour_over;
        else if (state == game_pkg::st_play && |hit)
            pixel_rgb = sprite_rgb;
        else if (in_paddle)
            pixel_rgb = game_pkg::colour_paddle;
        else
            pixel_rgb = game_pkg::colour_bg;
    end

    // A sprite pixel over a paddle pixel is a catch
    assign caught = (pix_en && raw_active && in_paddle && state == game_pkg::st_play)
                  ? hit : '0;

    // ------------------------------------------------------------------
    // Output stage, one pixel behind x and y

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            display_on <= 1'b0;
            rgb        <= '0;
        end else if (pix_en) begin
            hsync      <= raw_hsync;
            vsync      <= raw_vsync;
            display_on <= raw_active;
            rgb        <= pixel_rgb;
        end
    end

endmodule

`default_nettype wire

// File: logic/game_top.sv
`default_nettype none

module game_top #(
    parameter int clk_mhz                           = 50,
    parameter int pixel_mhz                         = 25,
    parameter int h_active                          = 640,
    parameter int h_front                           = 16,
    parameter int h_sync                            = 96,
    parameter int h_back                            = 48,
    parameter int v_active                          = 480,
    parameter int v_front                           = 10,
    parameter int v_sync                            = 2,
    parameter int v_back                            = 33,
    parameter int strobe_to_update_xy_counter_width = 20,
    parameter int n_sprites                         = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           launch_key,
    input  logic [1:0]     left_right_keys,
    output logic           hsync,
    output logic           vsync,
    output game_pkg::rgb_t rgb,
    output logic           display_on,
    output logic           pixel_clk
);

    logic                  pix_en;
    game_pkg::coord_t      x;
    game_pkg::coord_t      y;
    logic                  raw_hsync;
    logic                  raw_vsync;
    logic                  raw_active;
    logic                  step;
    logic [n_sprites-1:0]  respawn;
    logic [n_sprites-1:0]  hit;
    logic [n_sprites-1:0]  bottom;
    logic [n_sprites-1:0]  caught;
    game_pkg::coord_t      paddle_x;
    game_pkg::game_state_t state;

    // ------------------------------------------------------------------
    // Raster and game control

    vga_timing #(
        .clk_mhz    (clk_mhz),
        .pixel_mhz  (pixel_mhz),
        .h_active   (h_active),
        .h_front    (h_front),
        .h_sync     (h_sync),
        .h_back     (h_back),
        .v_active   (v_active),
        .v_front    (v_front),
        .v_sync     (v_sync),
        .v_back     (v_back)
    ) i_vga_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_en     (pix_en),
        .pixel_clk  (pixel_clk),
        .x          (x),
        .y          (y),
        .raw_hsync  (raw_hsync),
        .raw_vsync  (raw_vsync),
        .raw_active (raw_active),
        .frame_end  ()
    );

    game_control #(
        .h_active                          (h_active),
        .strobe_to_update_xy_counter_width (strobe_to_update_xy_counter_width),
        .n_sprites                         (n_sprites)
    ) i_game_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .launch_key      (launch_key),
        .left_right_keys (left_right_keys),
        .bottom          (bottom),
        .caught          (caught),
        .step            (step),
        .respawn         (respawn),
        .paddle_x        (paddle_x),
        .state           (state)
    );

    // ------------------------------------------------------------------
    // Sprites, each with its own row of the start tables

    for (genvar i = 0; i < n_sprites; i++) begin : g_sprite
        game_sprite #(
            .h_active (h_active),
            .v_active (v_active),
            .start_x  (game_pkg::sprite_start_x[i]),
            .start_y  (game_pkg::sprite_start_y[i]),
            .dx       (game_pkg::sprite_dx[i])
        ) i_game_sprite (
            .clk     (clk),
            .rst_n   (rst_n),
            .step    (step),
            .respawn (respawn[i]),
            .x       (x),
            .y       (y),
            .hit     (hit[i]),
            .bottom  (bottom[i])
        );
    end

    game_mixer #(
        .v_active  (v_active),
        .n_sprites (n_sprites)
    ) i_game_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_en     (pix_en),
        .x          (x),
        .y          (y),
        .raw_hsync  (raw_hsync),
        .raw_vsync  (raw_vsync),
        .raw_active (raw_active),
        .hit        (hit),
        .paddle_x   (paddle_x),
        .state      (state),
        .caught     (caught),
        .hsync      (hsync),
        .vsync      (vsync),
        .display_on (display_on),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

// File: sim/tb_game_top.sv
`default_nettype none

module tb_game_top;

    localparam int h_act = 32;
    localparam int v_act = 24;
    localparam int n_rows = 5;

    typedef enum {k_paddle, k_colours, k_red, k_relaunch} check_kind_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       launch_key;
    logic [1:0] left_right_keys;
    logic       hsync;
    logic       vsync;
    logic       display_on;
    logic       pixel_clk;
    game_pkg::rgb_t rgb;

    int errors;
    int n_pass;
    int n_fail;

    game_pkg::rgb_t frame [h_act*v_act];

    // ------------------------------------------------------------------
    // Stimulus table
    // The relaunch row pulses launch for one clk inside its check

    string       t_name   [n_rows] = '{"steer_right", "steer_left", "play_sprites",
                                       "game_over", "relaunch"};
    logic        t_launch [n_rows] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    logic [1:0]  t_keys   [n_rows] = '{2'b01, 2'b10, 2'b00, 2'b00, 2'b00};
    int          t_hold   [n_rows] = '{2, 2, 3, 6, 0};
    check_kind_t t_kind   [n_rows] = '{k_paddle, k_paddle, k_colours, k_red, k_relaunch};
    int          t_value  [n_rows] = '{16, 0, 2, h_act*v_act, 0};

    game_top #(
        .clk_mhz                           (50),
        .pixel_mhz                         (25),
        .h_active                          (h_act),
        .h_front                           (2),
        .h_sync                            (4),
        .h_back                            (4),
        .v_active                          (v_act),
        .v_front                           (1),
        .v_sync                            (2),
        .v_back                            (2),
        .strobe_to_update_xy_counter_width (4),
        .n_sprites                         (2)
    ) i_game_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .launch_key      (launch_key),
        .left_right_keys (left_right_keys),
        .hsync           (hsync),
        .vsync           (vsync),
        .rgb             (rgb),
        .display_on      (display_on),
        .pixel_clk       (pixel_clk)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic wait_vsync_fall(output logic ok);
        logic p_v;
        ok = 1'b0;
        p_v = vsync;
        for (int n = 0; n < 6000 && !ok; n++) begin
            @(negedge clk);
            if (p_v && !vsync)
                ok = 1'b1;
            p_v = vsync;
        end
        if (!ok) begin
            $display("timeout: vsync did not fall");
            errors++;
        end
    endtask

    // Rows and columns follow the display_on edges after a vsync
    task automatic capture_frame(output logic ok);
        logic p_clk;
        logic p_d;
        int   row;
        int   col;
        wait_vsync_fall(ok);
        if (!ok)
            return;
        ok = 1'b0;
        row = -1;
        col = 0;
        p_clk = pixel_clk;
        p_d = display_on;
        for (int n = 0; n < 6000 && !ok; n++) begin
            @(negedge clk);
            if (pixel_clk != p_clk) begin
                if (display_on && !p_d) begin
                    row++;
                    col = 0;
                end
                if (display_on && row >= 0 && row < v_act && col < h_act) begin
                    frame[row*h_act + col] = rgb;
                    col++;
                end
                if (!display_on && p_d && row == v_act - 1)
                    ok = 1'b1;
                p_d = display_on;
            end
            p_clk = pixel_clk;
        end
        if (!ok) begin
            $display("timeout: frame capture did not complete");
            errors++;
        end
    endtask

    function automatic int count_colour(input game_pkg::rgb_t c);
        int n;
        n = 0;
        for (int i = 0; i < h_act*v_act; i++)
            if (frame[i] == c)
                n++;
        return n;
    endfunction

    // Black frame with a white 16 by 4 paddle on the bottom rows
    task automatic check_paddle(input string name, input int left);
        game_pkg::rgb_t exp;
        int             bad;
        bad = 0;
        for (int r = 0; r < v_act; r++) begin
            for (int c = 0; c < h_act; c++) begin
                if (r >= v_act - 4 && c >= left && c < left + 16)
                    exp = 3'b111;
                else
                    exp = 3'b000;
                if (bad == 0) begin
                    assert (frame[r*h_act + c] == exp) else begin
                        $display("error %s: expected %0d, actual %0d at x %0d y %0d",
                                 name, exp, frame[r*h_act + c], c, r);
                        errors++;
                        bad++;
                    end
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Line and frame timing, in clk cycles over 2

    task automatic check_timing();
        logic ok;
        logic done;
        logic p_h;
        logic p_v;
        logic p_d;
        logic p_pc;
        int   cyc;
        int   t_hfall;
        int   t_hfall_first;
        int   t_don;
        logic don_open;
        int   lines;
        int   vlow;
        int   don_lines;
        int   blank_bad;
        int   toggles;
        wait_vsync_fall(ok);
        if (!ok)
            return;
        done = 1'b0;
        cyc = 0;
        t_hfall = -1;
        t_don = -1;
        don_open = 1'b0;
        lines = 0;
        vlow = 0;
        don_lines = 0;
        blank_bad = 0;
        toggles = 0;
        p_h = hsync;
        p_v = vsync;
        p_d = display_on;
        p_pc = pixel_clk;
        for (int n = 0; n < 5200 && !done; n++) begin
            @(negedge clk);
            cyc++;
            if (pixel_clk != p_pc)
                toggles++;
            if (p_h && !hsync) begin
                if (t_hfall >= 0)
                    check_value("hsync_period", 42, (cyc - t_hfall) / 2);
                if (don_open)
                    check_value("hsync_after_display", 34, (cyc - t_don) / 2);
                don_open = 1'b0;
                t_hfall = cyc;
                lines++;
                if (!vsync)
                    vlow++;
            end
            if (!p_h && hsync)
                check_value("hsync_width", 4, (cyc - t_hfall) / 2);
            if (!p_d && display_on) begin
                t_don = cyc;
                don_open = 1'b1;
                don_lines++;
            end
            if (p_d && !display_on)
                check_value("display_width", 32, (cyc - t_don) / 2);
            if (!display_on && rgb != 3'b000)
                blank_bad++;
            if (p_v && !vsync)
                done = 1'b1;
            p_h = hsync;
            p_v = vsync;
            p_d = display_on;
            p_pc = pixel_clk;
        end
        if (!done) begin
            $display("timeout: second vsync did not arrive");
            errors++;
        end
        check_value("vsync_period_lines", 29, lines);
        check_value("vsync_width_lines", 2, vlow);
        check_value("display_lines", 24, don_lines);
        check_value("rgb_blank", 0, blank_bad);
        // One pixel_clk edge per pixel over a whole frame
        check_value("pixel_clk_toggles", 29 * 42, toggles);
    endtask

    // Pixels right after a launch from game over are free of red
    task automatic check_relaunch(input string name);
        logic found;
        logic p_d;
        logic p_clk;
        int   seen;
        int   reds;
        found = 1'b0;
        p_d = display_on;
        for (int n = 0; n < 3000 && !found; n++) begin
            @(negedge clk);
            if (display_on && !p_d)
                found = 1'b1;
            p_d = display_on;
        end
        if (!found) begin
            $display("timeout: no active line started before relaunch");
            errors++;
            return;
        end
        @(posedge clk);
        launch_key <= 1'b1;
        @(posedge clk);
        launch_key <= 1'b0;
        @(negedge clk);
        seen = 0;
        reds = 0;
        p_clk = pixel_clk;
        for (int n = 0; n < 100 && seen < 16; n++) begin
            @(negedge clk);
            if (pixel_clk != p_clk) begin
                seen++;
                if (rgb == game_pkg::colour_over)
                    reds++;
            end
            p_clk = pixel_clk;
        end
        check_value(name, 0, reds);
    endtask

    task automatic run_row(input int r);
        logic ok;
        int   seen;
        int   reds;
        if (t_kind[r] != k_relaunch) begin
            @(posedge clk);
            launch_key      <= t_launch[r];
            left_right_keys <= t_keys[r];
        end
        case (t_kind[r])
            k_paddle: begin
                for (int f = 0; f < t_hold[r]; f++)
                    wait_vsync_fall(ok);
                capture_frame(ok);
                if (ok)
                    check_paddle(t_name[r], t_value[r]);
            end
            k_colours: begin
                seen = 0;
                for (int f = 0; f < t_hold[r]; f++) begin
                    capture_frame(ok);
                    if (count_colour(game_pkg::sprite_colour[0]) > 0)
                        seen |= 1;
                    if (count_colour(game_pkg::sprite_colour[1]) > 0)
                        seen |= 2;
                end
                check_value(t_name[r], t_value[r], (seen & 1) + (seen >> 1));
            end
            k_red: begin
                reds = 0;
                for (int f = 0; f < t_hold[r] && reds != t_value[r]; f++) begin
                    capture_frame(ok);
                    reds = count_colour(game_pkg::colour_over);
                end
                check_value(t_name[r], t_value[r], reds);
            end
            default:
                check_relaunch(t_name[r]);
        endcase
    endtask

    // ------------------------------------------------------------------
    // Main sequence

    initial begin
        int  e0;
        logic ok;
        rst_n = 1'b0;
        launch_key = 1'b0;
        left_right_keys = 2'b00;
        errors = 0;
        n_pass = 0;
        n_fail = 0;

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i == 7)
                @(posedge clk) rst_n <= 1'b1;
            check_value("reset_hsync", 1, hsync);
            check_value("reset_vsync", 1, vsync);
            check_value("reset_display_on", 0, display_on);
            check_value("reset_rgb", 0, rgb);
        end
        report_test("reset_state", e0);

        e0 = errors;
        check_timing();
        report_test("line_and_frame_timing", e0);

        e0 = errors;
        capture_frame(ok);
        if (ok)
            check_paddle("idle_picture", 8);
        report_test("idle_picture", e0);

        for (int r = 0; r < n_rows; r++) begin
            e0 = errors;
            run_row(r);
            report_test(t_name[r], e0);
        end

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sprite_game.f
logic/game_pkg.sv
logic/vga_timing.sv
logic/game_control.sv
logic/game_sprite.sv
logic/game_mixer.sv
logic/game_top.sv
sim/tb_game_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_game_top -f sprite_game.f

./obj_dir/Vtb_game_top > sim.log
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
